/* mult_pkg.sv */
//////////////////////////////////////////////////
// shared types for the subword multiplier / MAC
// operator encoding, word and subword types, the
// request bundle from the execute stage and the
// control bundle of the high-word sequencer
// import with a wildcard in the module header
//////////////////////////////////////////////////

package mult_pkg;

  // data word width of the core
  localparam int WORD_W = 32;

  // operator encoding, 4 bits as in the decoder
  typedef enum logic [3:0] {
    MUL_MAC32 = 4'h0,
    MUL_MSU32 = 4'h1,
    MUL_I     = 4'h2,
    MUL_IR    = 4'h3,
    MUL_H     = 4'h4,
    MUL_DOT8  = 4'h5,
    MUL_DOT4  = 4'h6,
    MUL_DOT2  = 4'h7,
    MUL_DOT16 = 4'h8
  } mult_op_e;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [15:0]       half_t;
  typedef logic [4:0]        imm_t;

  // bit 1: operand b signed, bit 0: operand a signed
  typedef logic [1:0] sign_sel_t;

  // request from the execute stage, 110 bits
  typedef struct packed {
    mult_op_e  operator;
    logic      short_subword;
    sign_sel_t short_signed;
    sign_sel_t dot_signed;
    imm_t      imm;
    word_t     op_a;
    word_t     op_b;
    word_t     op_c;
  } mult_req_t;

  // sequencer overrides for the short datapath, 11 bits
  // subword has one select per operand, bit 0 for a
  typedef struct packed {
    logic      active;
    imm_t      imm;
    logic [1:0] subword;
    sign_sel_t signed_sel;
    logic      shift_arith;
  } mulh_ctl_t;

endpackage

/* mult_int_mac.sv */
//////////////////////////////////////////////////
// 32x32 multiply-accumulate / multiply-subtract
// purely combinational, low 32 bits of the result
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mult_int_mac
  import mult_pkg::*;
(
  input  word_t a_i,
  input  word_t b_i,
  input  word_t c_i,
  input  logic  msu_i,
  output word_t result_o
);

  word_t a_msu;
  word_t b_msu;

  // c - a*b = c + (~a + 1)*b = c + ~a*b + b
  // so the one multiplier covers both forms
  assign a_msu = a_i ^ {WORD_W{msu_i}};

  // extra b term only for the subtract
  assign b_msu = b_i & {WORD_W{msu_i}};

  // everything wraps at 32 bits, sign does not matter for the low word
  assign result_o = c_i + b_msu + a_msu * b_i;

endmodule

/* mult_short_dp.sv */
//////////////////////////////////////////////////
// 16x16 subword multiply with accumulate, round
// and right shift; also the shared datapath of
// the high-word multiply, steered by the
// sequencer control bundle while it is active
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mult_short_dp
  import mult_pkg::*;
(
  input  mult_req_t req_i,
  input  logic      round_en_i,
  input  mulh_ctl_t mulh_ctl_i,
  input  logic      carry_i,
  output logic      carry_o,
  output word_t     result_o
);

  // effective controls after the sequencer override
  imm_t        short_imm;
  logic [1:0]  short_subword;
  sign_sel_t   short_signed;
  logic        short_shift_arith;

  half_t       half_a;
  half_t       half_b;
  logic [16:0] op_a_ext;
  logic [16:0] op_b_ext;
  logic [32:0] op_c_ext;
  logic [33:0] short_mul;
  logic [33:0] short_mac;
  word_t       round_tmp;
  word_t       round_val;
  logic        mac_msb1;
  logic        mac_msb0;
  logic [33:0] short_shifted;

  //////////////////////////////////////////////////
  // control select
  //////////////////////////////////////////////////

  assign short_imm         = mulh_ctl_i.active ? mulh_ctl_i.imm         : req_i.imm;
  assign short_subword     = mulh_ctl_i.active ? mulh_ctl_i.subword
                                               : {2{req_i.short_subword}};
  assign short_signed      = mulh_ctl_i.active ? mulh_ctl_i.signed_sel  : req_i.short_signed;
  // b can only be signed when a is, so a's sign decides the shift
  assign short_shift_arith = mulh_ctl_i.active ? mulh_ctl_i.shift_arith
                                               : req_i.short_signed[0];

  //////////////////////////////////////////////////
  // operands
  //////////////////////////////////////////////////

  // half select per operand
  assign half_a = short_subword[0] ? req_i.op_a[31:16] : req_i.op_a[15:0];
  assign half_b = short_subword[1] ? req_i.op_b[31:16] : req_i.op_b[15:0];

  // 17-bit operands, msb is zero for unsigned halves
  assign op_a_ext = {short_signed[0] & half_a[15], half_a};
  assign op_b_ext = {short_signed[1] & half_b[15], half_b};

  // high-word steps extend the accumulator with the stored carry
  assign op_c_ext = mulh_ctl_i.active ? {carry_i, req_i.op_c}
                                      : {req_i.op_c[31], req_i.op_c};

  // half an lsb at the shift position, zero when imm is zero
  assign round_tmp = word_t'(1) << req_i.imm;
  assign round_val = round_en_i ? {1'b0, round_tmp[31:1]} : '0;

  //////////////////////////////////////////////////
  // multiply, add, shift
  //////////////////////////////////////////////////

  assign short_mul = $signed(op_a_ext) * $signed(op_b_ext);
  assign short_mac = {op_c_ext[32], op_c_ext} + short_mul + {2'b00, round_val};

  // the 34-bit sum is only meaningful during the high-word steps
  assign mac_msb1 = mulh_ctl_i.active ? short_mac[33] : short_mac[31];
  assign mac_msb0 = mulh_ctl_i.active ? short_mac[32] : short_mac[31];

  assign short_shifted = $signed({short_shift_arith & mac_msb1,
                                  short_shift_arith & mac_msb0,
                                  short_mac[31:0]}) >>> short_imm;

  assign result_o = short_shifted[31:0];

  // carry out of the low word, saved by the sequencer in step 1
  assign carry_o = short_mac[32];

endmodule

/* mult_mulh_seq.sv */
//////////////////////////////////////////////////
// sequencer of the multicycle high-word multiply
// walks four partial products through the 16-bit
// datapath and keeps the carry between steps
// accept: idle and start_i high at a rising edge
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mult_mulh_seq
  import mult_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start_i,
  input  logic      ex_ready_i,
  input  sign_sel_t short_signed_i,
  input  logic      mac_carry_i,
  output mulh_ctl_t ctl_o,
  output logic      carry_o,
  output logic      ready_o,
  output logic      multicycle_o
);

  typedef enum logic [2:0] {
    IDLE,
    STEP0,
    STEP1,
    STEP2,
    FINISH
  } seq_state_e;

  seq_state_e state_q;
  seq_state_e state_d;
  logic       carry_q;
  logic       carry_save;
  logic       carry_clear;

  //////////////////////////////////////////////////
  // next state and datapath control
  //////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    ctl_o          = '0;
    ctl_o.active   = 1'b1;
    carry_save     = 1'b0;
    carry_clear    = 1'b0;
    ready_o        = 1'b0;
    multicycle_o   = 1'b0;

    case (state_q)
      IDLE: begin
        ctl_o.active = 1'b0;
        ready_o      = 1'b1;
        if (start_i) begin
          ready_o = 1'b0;
          state_d = STEP0;
        end
      end

      // al*bl, unsigned, never carries
      STEP0: begin
        multicycle_o = 1'b1;
        ctl_o.imm    = imm_t'(16);
        state_d      = STEP1;
      end

      // al*bh, signed only if b is, 33-bit sum so keep the carry
      STEP1: begin
        multicycle_o      = 1'b1;
        ctl_o.signed_sel  = {short_signed_i[1], 1'b0};
        ctl_o.subword     = 2'b10;
        ctl_o.shift_arith = 1'b1;
        carry_save        = 1'b1;
        state_d           = STEP2;
      end

      // ah*bl, signed only if a is
      // bits 33:32 get shifted back in, so the carry is dropped
      STEP2: begin
        multicycle_o      = 1'b1;
        ctl_o.signed_sel  = {1'b0, short_signed_i[0]};
        ctl_o.subword     = 2'b01;
        ctl_o.imm         = imm_t'(16);
        ctl_o.shift_arith = 1'b1;
        carry_save        = 1'b1;
        carry_clear       = 1'b1;
        state_d           = FINISH;
      end

      // ah*bh with the requested signedness gives the high word
      FINISH: begin
        ctl_o.signed_sel = short_signed_i;
        ctl_o.subword    = 2'b11;
        ready_o          = 1'b1;
        // hold until the pipeline takes the result
        if (ex_ready_i) begin
          state_d = IDLE;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // state and carry registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      carry_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (carry_save) begin
        carry_q <= ~carry_clear & mac_carry_i;
      end else if (ex_ready_i) begin
        // next instruction must start without a stale carry
        carry_q <= 1'b0;
      end
    end
  end

  assign carry_o = carry_q;

  // accepted op runs through the three steps back to back into finish
  assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == IDLE && start_i) |=> (state_q == STEP0) ##1 (state_q == STEP1)
                                     ##1 (state_q == STEP2) ##1 (state_q == FINISH));

  // a busy unit never reports a valid result
  assert property (@(posedge clk) disable iff (!rst_n)
    !(multicycle_o && ready_o));

endmodule

/* mult_dot_lanes.sv */
//////////////////////////////////////////////////
// dot product over equal-width lanes of two words
// plus accumulator, low 32 bits kept
// ELEM_W sets the lane width: 2, 4, 8 or 16
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mult_dot_lanes
  import mult_pkg::*;
#(
  parameter int ELEM_W = 8
) (
  input  word_t     a_i,
  input  word_t     b_i,
  input  word_t     c_i,
  input  sign_sel_t signed_i,
  output word_t     sum_o
);

  localparam int N_LANES = WORD_W / ELEM_W;

  // one extra bit per lane for the sign extension
  logic  [N_LANES-1:0][ELEM_W:0] lane_a;
  logic  [N_LANES-1:0][ELEM_W:0] lane_b;
  // products kept at word width, the sum wraps anyway
  word_t [N_LANES-1:0]           lane_prod;

  for (genvar i = 0; i < N_LANES; i++) begin : g_lane
    // msb of each lane is its sign when the operand is signed
    assign lane_a[i] = {signed_i[0] & a_i[i*ELEM_W+ELEM_W-1], a_i[i*ELEM_W +: ELEM_W]};
    assign lane_b[i] = {signed_i[1] & b_i[i*ELEM_W+ELEM_W-1], b_i[i*ELEM_W +: ELEM_W]};

    // operands get sign-extended to 32 bits before the multiply
    assign lane_prod[i] = $signed(lane_a[i]) * $signed(lane_b[i]);
  end

  // adder tree left to synthesis
  always_comb begin
    sum_o = c_i;
    for (int i = 0; i < N_LANES; i++) begin
      sum_o = sum_o + lane_prod[i];
    end
  end

endmodule

/* mult_top.sv */
//////////////////////////////////////////////////
// subword multiplier / MAC of the execute stage
// decodes the operator, runs the MAC, short and
// dot datapaths and selects the result
// MUL_H takes four cycles; hold req_i stable until
// ready_o is high and ex_ready_i takes the result
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mult_top
  import mult_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      enable_i,
  input  mult_req_t req_i,
  input  logic      ex_ready_i,
  output word_t     result_o,
  output logic      ready_o,
  output logic      multicycle_o
);

  logic        mulh_start;
  logic        round_en;
  logic        msu;
  mulh_ctl_t   mulh_ctl;
  logic        mulh_carry;
  logic        mac_carry;
  // running partial sum of the high-word steps
  word_t       partial_q;
  mult_req_t   short_req;
  word_t       int_result;
  word_t       short_result;
  word_t       dot8_result;
  word_t       dot4_result;
  word_t       dot2_result;
  word_t       dot16_result;
  logic [63:0] mulh_full;

  //////////////////////////////////////////////////
  // operator decode
  //////////////////////////////////////////////////

  assign mulh_start = enable_i && (req_i.operator == MUL_H);
  assign round_en   = (req_i.operator == MUL_IR);
  assign msu        = (req_i.operator == MUL_MSU32);

  //////////////////////////////////////////////////
  // high-word multiply
  //////////////////////////////////////////////////

  mult_mulh_seq u_mulh_seq (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (mulh_start),
    .ex_ready_i     (ex_ready_i),
    .short_signed_i (req_i.short_signed),
    .mac_carry_i    (mac_carry),
    .ctl_o          (mulh_ctl),
    .carry_o        (mulh_carry),
    .ready_o        (ready_o),
    .multicycle_o   (multicycle_o)
  );

  // each step result accumulates into the next one
  // zero in idle so step 0 starts from nothing
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      partial_q <= '0;
    end else if (multicycle_o) begin
      partial_q <= short_result;
    end else if (ex_ready_i) begin
      partial_q <= '0;
    end
  end

  // sequencer feeds its partial sum in place of op_c
  always_comb begin
    short_req = req_i;
    if (mulh_ctl.active) begin
      short_req.op_c = partial_q;
    end
  end

  //////////////////////////////////////////////////
  // datapaths
  //////////////////////////////////////////////////

  mult_int_mac u_int_mac (
    .a_i      (req_i.op_a),
    .b_i      (req_i.op_b),
    .c_i      (req_i.op_c),
    .msu_i    (msu),
    .result_o (int_result)
  );

  mult_short_dp u_short_dp (
    .req_i      (short_req),
    .round_en_i (round_en),
    .mulh_ctl_i (mulh_ctl),
    .carry_i    (mulh_carry),
    .carry_o    (mac_carry),
    .result_o   (short_result)
  );

  mult_dot_lanes #(.ELEM_W(8)) u_dot8 (
    .a_i (req_i.op_a), .b_i (req_i.op_b), .c_i (req_i.op_c),
    .signed_i (req_i.dot_signed), .sum_o (dot8_result)
  );

  mult_dot_lanes #(.ELEM_W(4)) u_dot4 (
    .a_i (req_i.op_a), .b_i (req_i.op_b), .c_i (req_i.op_c),
    .signed_i (req_i.dot_signed), .sum_o (dot4_result)
  );

  mult_dot_lanes #(.ELEM_W(2)) u_dot2 (
    .a_i (req_i.op_a), .b_i (req_i.op_b), .c_i (req_i.op_c),
    .signed_i (req_i.dot_signed), .sum_o (dot2_result)
  );

  mult_dot_lanes #(.ELEM_W(16)) u_dot16 (
    .a_i (req_i.op_a), .b_i (req_i.op_b), .c_i (req_i.op_c),
    .signed_i (req_i.dot_signed), .sum_o (dot16_result)
  );

  //////////////////////////////////////////////////
  // result select
  //////////////////////////////////////////////////

  always_comb begin
    case (req_i.operator)
      MUL_MAC32, MUL_MSU32: result_o = int_result;
      MUL_I, MUL_IR, MUL_H: result_o = short_result;
      MUL_DOT8:             result_o = dot8_result;
      MUL_DOT4:             result_o = dot4_result;
      MUL_DOT2:             result_o = dot2_result;
      MUL_DOT16:            result_o = dot16_result;
      default:              result_o = '0;
    endcase
  end

  // full 64-bit product with the requested signedness
  assign mulh_full = {{32{req_i.short_signed[0] & req_i.op_a[31]}}, req_i.op_a} *
                     {{32{req_i.short_signed[1] & req_i.op_b[31]}}, req_i.op_b};

  // in finish the four partial products must add up to the high word
  assert property (@(posedge clk) disable iff (!rst_n)
    (mulh_ctl.active && !multicycle_o && req_i.operator == MUL_H)
      |-> (result_o == mulh_full[63:32]));

endmodule

/* tb_mult_model.svh */
//////////////////////////////////////////////////
// reference model of the multiplier operators
// plain functions on request fields, included in
// the testbench after the package import
//////////////////////////////////////////////////

`ifndef TB_MULT_MODEL_SVH
`define TB_MULT_MODEL_SVH

// c + a*b or c - a*b, low word only
function automatic word_t mac_model(word_t a, word_t b, word_t c, logic msu);
  logic [63:0] prod;
  prod = {32'b0, a} * {32'b0, b};
  if (msu) begin
    return c - prod[31:0];
  end else begin
    return c + prod[31:0];
  end
endfunction

// halves times halves plus c, optional rounding, then right shift
// the shift is arithmetic when a is signed
function automatic word_t short_model(word_t a, word_t b, word_t c, logic upper,
                                      sign_sel_t sgn, imm_t imm, logic rnd);
  half_t  ha;
  half_t  hb;
  longint va;
  longint vb;
  longint sum;
  word_t  sum_w;
  ha = upper ? a[31:16] : a[15:0];
  hb = upper ? b[31:16] : b[15:0];
  va = sgn[0] ? longint'($signed(ha)) : longint'(ha);
  vb = sgn[1] ? longint'($signed(hb)) : longint'(hb);
  sum = longint'(c) + va * vb;
  // half an lsb at the shift position
  if (rnd && imm != 0) begin
    sum = sum + (longint'(1) << (int'(imm) - 1));
  end
  sum_w = sum[31:0];
  if (sgn[0]) begin
    return word_t'($signed(sum_w) >>> imm);
  end else begin
    return sum_w >> imm;
  end
endfunction

// upper word of the full 64-bit product
function automatic word_t mulh_model(word_t a, word_t b, sign_sel_t sgn);
  longint va;
  longint vb;
  longint prod;
  va   = sgn[0] ? longint'($signed(a)) : longint'(a);
  vb   = sgn[1] ? longint'($signed(b)) : longint'(b);
  // wraps mod 2^64, upper bits stay right
  prod = va * vb;
  return prod[63:32];
endfunction

// c plus the sum of lane products, lanes of elem_w bits
function automatic word_t dot_model(word_t a, word_t b, word_t c, sign_sel_t sgn,
                                    int elem_w);
  longint acc;
  longint va;
  longint vb;
  longint mask;
  int     lanes;
  lanes = WORD_W / elem_w;
  mask  = (longint'(1) << elem_w) - 1;
  acc   = longint'(c);
  for (int i = 0; i < lanes; i++) begin
    va = (longint'(a) >> (i * elem_w)) & mask;
    vb = (longint'(b) >> (i * elem_w)) & mask;
    // top lane bit set means negative for a signed operand
    if (sgn[0] && ((va >> (elem_w - 1)) & 1) != 0) begin
      va = va - (longint'(1) << elem_w);
    end
    if (sgn[1] && ((vb >> (elem_w - 1)) & 1) != 0) begin
      vb = vb - (longint'(1) << elem_w);
    end
    acc = acc + va * vb;
  end
  return acc[31:0];
endfunction

`endif

/* tb_mult_top.sv */
//////////////////////////////////////////////////
// testbench of the subword multiplier / MAC
// random requests from a fixed seed, checked
// against the model functions; MUL_H is run
// through its sequence with random back-pressure
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_mult_top
  import mult_pkg::*;
();

  localparam int MAX_WAIT = 20;

  logic      clk;
  logic      rst_n;
  logic      enable;
  mult_req_t req;
  logic      ex_ready;
  word_t     result;
  logic      ready;
  logic      multicycle;

  integer    seed;
  int        total_checks;
  int        total_errors;
  int        test_checks;
  int        test_errors;
  string     test_name;
  logic      timed_out;

  `include "tb_mult_model.svh"

  mult_top dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (enable),
    .req_i        (req),
    .ex_ready_i   (ex_ready),
    .result_o     (result),
    .ready_o      (ready),
    .multicycle_o (multicycle)
  );

  // 8 ns period
  always #4 clk = ~clk;

  //////////////////////////////////////////////////
  // compare and report
  //////////////////////////////////////////////////

  task automatic check_word(input string name, input word_t exp, input word_t act);
    test_checks++;
    if (act !== exp) begin
      test_errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    test_checks++;
    if (act !== exp) begin
      test_errors++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic open_test(input string name);
    test_name   = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic close_test();
    $display("%s: %0d checks, %0d errors", test_name, test_checks, test_errors);
    total_checks += test_checks;
    total_errors += test_errors;
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  // every field random, caller overrides what matters
  task automatic fill_request(input mult_op_e op, output mult_req_t r);
    r               = '0;
    r.operator      = op;
    r.short_subword = 1'($random(seed));
    r.short_signed  = sign_sel_t'($random(seed));
    r.dot_signed    = sign_sel_t'($random(seed));
    r.imm           = imm_t'($random(seed));
    r.op_a          = word_t'($random(seed));
    r.op_b          = word_t'($random(seed));
    r.op_c          = word_t'($random(seed));
  endtask

  // b signed only together with a: 00, 01 or 11
  function automatic sign_sel_t pick_short_sign();
    int sel;
    sel = $unsigned($random(seed)) % 3;
    case (sel)
      0:       return 2'b00;
      1:       return 2'b01;
      default: return 2'b11;
    endcase
  endfunction

  task automatic mac_case(input logic msu);
    mult_req_t r;
    word_t     exp;
    if (msu) begin
      fill_request(MUL_MSU32, r);
    end else begin
      fill_request(MUL_MAC32, r);
    end
    exp = mac_model(r.op_a, r.op_b, r.op_c, msu);
    @(posedge clk);
    #1;
    req = r;
    @(negedge clk);
    check_word(msu ? "msu32" : "mac32", exp, result);
    check_bit("mac ready", 1'b1, ready);
  endtask

  task automatic short_case();
    mult_req_t r;
    word_t     exp;
    string     name;
    fill_request(MUL_I, r);
    name = "mul_i";
    if ($random(seed) & 1) begin
      r.operator = MUL_IR;
      name       = "mul_ir";
    end
    r.short_signed = pick_short_sign();
    exp = short_model(r.op_a, r.op_b, r.op_c, r.short_subword, r.short_signed,
                      r.imm, r.operator == MUL_IR);
    @(posedge clk);
    #1;
    req = r;
    @(negedge clk);
    check_word(name, exp, result);
    check_bit({name, " ready"}, 1'b1, ready);
  endtask

  // one high-word multiply with 0 to 3 cycles of back-pressure in finish
  task automatic mulh_case(input string name);
    mult_req_t r;
    word_t     exp;
    word_t     busy;
    int        hold;
    fill_request(MUL_H, r);
    r.short_signed = pick_short_sign();
    hold = $unsigned($random(seed)) % 4;
    exp  = mulh_model(r.op_a, r.op_b, r.short_signed);
    @(posedge clk);
    #1;
    req      = r;
    enable   = 1'b1;
    ex_ready = (hold == 0);
    // acceptance edge, request stays put from here
    @(posedge clk);
    #1;
    enable = 1'b0;
    busy   = '0;
    @(negedge clk);
    while (!ready && busy < MAX_WAIT) begin
      check_bit({name, " busy"}, 1'b1, multicycle);
      busy++;
      @(negedge clk);
    end
    if (!ready) begin
      $display("ERROR: %s: ready_o did not rise within %0d cycles of acceptance",
               name, MAX_WAIT);
      test_errors++;
      timed_out = 1'b1;
    end else begin
      check_word({name, " busy cycles"}, word_t'(3), busy);
      check_bit({name, " multicycle done"}, 1'b0, multicycle);
      check_word(name, exp, result);
      // finish has to hold while the pipeline stalls
      for (int k = 0; k < hold; k++) begin
        @(posedge clk);
        #1;
        if (k == hold - 1) begin
          ex_ready = 1'b1;
        end
        @(negedge clk);
        check_bit({name, " ready held"}, 1'b1, ready);
        check_word({name, " result held"}, exp, result);
      end
    end
  endtask

  task automatic dot_case(input mult_op_e op, input int elem_w, input string name);
    mult_req_t r;
    word_t     exp;
    fill_request(op, r);
    exp = dot_model(r.op_a, r.op_b, r.op_c, r.dot_signed, elem_w);
    @(posedge clk);
    #1;
    req = r;
    @(negedge clk);
    check_word(name, exp, result);
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    seed         = 1087;
    total_checks = 0;
    total_errors = 0;
    test_checks  = 0;
    test_errors  = 0;
    test_name    = "";
    timed_out    = 1'b0;
    clk          = 1'b0;
    rst_n        = 1'b0;
    enable       = 1'b0;
    req          = '0;
    ex_ready     = 1'b1;

    // two cycles of reset
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    open_test("reset");
    @(negedge clk);
    check_bit("reset ready", 1'b1, ready);
    check_bit("reset multicycle", 1'b0, multicycle);
    close_test();

    open_test("mac32_msu32");
    for (int i = 0; i < 200; i++) begin
      mac_case(1'(i));
    end
    close_test();

    open_test("mul_i_ir");
    for (int i = 0; i < 200; i++) begin
      short_case();
    end
    close_test();

    open_test("mul_h");
    for (int i = 0; i < 30; i++) begin
      if (timed_out) begin
        break;
      end
      mulh_case("mul_h");
    end
    close_test();

    if (!timed_out) begin
      open_test("dot");
      for (int i = 0; i < 50; i++) begin
        dot_case(MUL_DOT8, 8, "dot8");
        dot_case(MUL_DOT4, 4, "dot4");
        dot_case(MUL_DOT2, 2, "dot2");
        dot_case(MUL_DOT16, 16, "dot16");
      end
      close_test();
    end

    // mul_i right behind mul_h, then the next mul_h right behind that
    if (!timed_out) begin
      open_test("back_to_back");
      for (int i = 0; i < 10; i++) begin
        mulh_case("b2b mul_h");
        if (timed_out) begin
          break;
        end
        short_case();
      end
      close_test();
    end

    $display("total: %0d checks, %0d errors", total_checks, total_errors);
    if (total_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* mult_top.f */
+incdir+.
mult_pkg.sv
mult_int_mac.sv
mult_short_dp.sv
mult_mulh_seq.sv
mult_dot_lanes.sv
mult_top.sv
tb_mult_top.sv
